/* filelist.f */
logic/modPkg.sv
logic/PrefixAndOr.sv
logic/PrefixAndOrCendaround.sv
logic/AddMod2Np1.sv
logic/ModCfgIf.sv
logic/ModCfgReg.sv
logic/ModResidueUnit.sv
logic/ModAluTop.sv
dv/ClkGen.sv
dv/ModAluTb.sv

/* Bender.yml */
package:
  name: mod_alu

sources:
  - logic/modPkg.sv
  - logic/PrefixAndOr.sv
  - logic/PrefixAndOrCendaround.sv
  - logic/AddMod2Np1.sv
  - logic/ModCfgIf.sv
  - logic/ModCfgReg.sv
  - logic/ModResidueUnit.sv
  - logic/ModAluTop.sv
  - target: test
    files:
      - dv/ClkGen.sv
      - dv/ModAluTb.sv

/* dv/ModAluTb.sv */
`timescale 1ns/10ps

module ModAluTb;
	import modPkg::*;

	localparam int width   = 8;
	localparam int modulus = 2**width + 1; // 257

	typedef logic [width-1:0] wordT;

	typedef struct {
		bit                  isCfg;    // config write or operand strobe
		logic [cfgWidth-1:0] cfgData;
		int                  a;        // plain residues 0..256
		int                  b;
		int                  expected; // plain result of a data row
		modOpE               expOp;
	} rowT;

	logic                clk, rstN;
	logic                cfgWe, inValid, aZero, bZero;
	logic [cfgWidth-1:0] cfgData;
	wordT                aVal, bVal, resVal;
	logic                outValid, resZero;

	rowT   stim[$];
	modOpE mOp;  // reference model state
	int    mAcc;
	int    resErrors, opErrors, flagErrors;
	int    cycles, cycleLimit;

	ClkGen #(.period(20), .resetCycles(3)) clkGen (.clk(clk), .rstN(rstN));

	ModAluTop #(.width(width), .speed(1)) UUT (
		.clk(clk), .rstN(rstN), .cfgWe(cfgWe), .cfgData(cfgData),
		.inValid(inValid), .aVal(aVal), .aZero(aZero), .bVal(bVal), .bZero(bZero),
		.outValid(outValid), .resVal(resVal), .resZero(resZero)
	);

	// plain value to diminished-one word
	function automatic wordT toDim(input int x);
		return (x == 0) ? '0 : wordT'(x - 1);
	endfunction

	// model step that fills expected for the row
	task automatic addRow(input bit isCfg, input logic [cfgWidth-1:0] cd,
		input int a, input int b);
		rowT r;
		r.isCfg   = isCfg;
		r.cfgData = cd;
		r.a       = a;
		r.b       = b;
		if (isCfg) begin
			if (cd[cfgOpLsb +: 2] != 2'd3) mOp = modOpE'(cd[cfgOpLsb +: 2]); // 3 is reserved
			if (cd[cfgClrBit]) mAcc = 0;         // clear beats load
			else if (cd[cfgLoadBit]) mAcc = a;
		end else begin
			case (mOp)
				opSub:   r.expected = (a - b + modulus) % modulus;
				opAcc: begin
					mAcc       = (mAcc + a) % modulus;
					r.expected = mAcc;
				end
				default: r.expected = (a + b) % modulus;
			endcase
		end
		r.expOp = mOp;
		stim.push_back(r);
	endtask

	task automatic checkRes(input wordT expVal, input logic expZero);
		if (resVal !== expVal) begin
			resErrors++;
			$display("FAILED t=%0t resVal expected %h got %h", $time, expVal, resVal);
		end
		if (resZero !== expZero) begin
			resErrors++;
			$display("FAILED t=%0t resZero expected %b got %b", $time, expZero, resZero);
		end
	endtask

	task automatic checkOp(input modOpE expOp);
		modOpE got;
		got = UUT.cfgBus.op; // op register behind the interface
		if (got !== expOp) begin
			opErrors++;
			$display("FAILED t=%0t op expected %0d got %0d", $time, expOp, got);
		end
	endtask

	task automatic checkFlag(input logic expV, input logic got, input string name);
		if (got !== expV) begin
			flagErrors++;
			$display("FAILED t=%0t %s expected %b got %b", $time, name, expV, got);
		end
	endtask

	// watchdog
	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycleLimit > 0 && cycles >= cycleLimit) begin
			$display("timeout: run did not finish within %0d cycles", cycleLimit);
			$display("Result: FAILED");
			$finish;
		end
	end

	initial begin
		rowT r;
		cfgWe      = 1'b0;
		cfgData    = '0;
		inValid    = 1'b0;
		aVal       = '0;
		aZero      = 1'b0;
		bVal       = '0;
		bZero      = 1'b0;
		cycles     = 0;
		cycleLimit = 0;
		resErrors  = 0;
		opErrors   = 0;
		flagErrors = 0;
		mOp        = opAdd; // reset state
		mAcc       = 0;
		void'($urandom(73202));

		// add corners with op add out of reset
		addRow(0, 4'b0000, 1, 1);
		addRow(0, 4'b0000, 256, 256);
		addRow(0, 4'b0000, 256, 1);   // wraps to zero
		addRow(0, 4'b0000, 100, 157); // sum is the modulus
		addRow(0, 4'b0000, 0, 0);
		addRow(0, 4'b0000, 0, 42);
		addRow(0, 4'b0000, 42, 0);
		addRow(0, 4'b0000, 128, 129);
		repeat (10) addRow(0, 4'b0000, $urandom_range(modulus - 1, 0),
			$urandom_range(modulus - 1, 0));
		// subtract
		addRow(1, 4'b0001, 0, 0);
		addRow(0, 4'b0000, 5, 5);
		addRow(0, 4'b0000, 0, 7);
		addRow(0, 4'b0000, 7, 0);
		addRow(0, 4'b0000, 1, 256);
		addRow(0, 4'b0000, 256, 1);
		addRow(0, 4'b0000, 0, 0);
		addRow(0, 4'b0000, 200, 56);
		repeat (10) addRow(0, 4'b0000, $urandom_range(modulus - 1, 0),
			$urandom_range(modulus - 1, 0));
		addRow(1, 4'b0011, 0, 0);     // reserved op keeps sub
		addRow(0, 4'b0000, 10, 20);
		// accumulate from a clear with b as noise
		addRow(1, 4'b0110, 0, 0);
		addRow(0, 4'b0000, 5, 99);
		addRow(0, 4'b0000, 250, 3);
		addRow(0, 4'b0000, 2, 0);     // lands on zero
		repeat (6) addRow(0, 4'b0000, $urandom_range(modulus - 1, 0),
			$urandom_range(modulus - 1, 0));
		addRow(1, 4'b1010, 200, 0);   // load 200
		addRow(0, 4'b0000, 57, 11);
		addRow(0, 4'b0000, 256, 0);
		addRow(1, 4'b1011, 9, 0);     // reserved op with load
		addRow(0, 4'b0000, 1, 0);
		addRow(1, 4'b1110, 30, 0);    // clear and load where clear wins
		addRow(0, 4'b0000, 0, 0);
		addRow(0, 4'b0000, 77, 0);
		addRow(1, 4'b0000, 0, 0);     // back to add
		addRow(0, 4'b0000, 3, 4);
		cycleLimit = stim.size() * 4 + 50;

		wait (rstN === 1'b1);
		@(negedge clk);
		checkFlag(1'b0, outValid, "outValid");
		checkOp(opAdd);

		foreach (stim[i]) begin
			r = stim[i];
			@(posedge clk);
			aVal  <= toDim(r.a);
			aZero <= (r.a == 0);
			if (r.isCfg) begin
				cfgWe   <= 1'b1;
				cfgData <= r.cfgData;
				@(posedge clk);
				cfgWe <= 1'b0;
				@(negedge clk);
				checkOp(r.expOp);
				@(posedge clk); // clear/load pulse lands here
			end else begin
				inValid <= 1'b1;
				bVal    <= toDim(r.b);
				bZero   <= (r.b == 0);
				@(negedge clk);
				checkFlag(1'b0, outValid, "outValid"); // nothing early
				@(posedge clk);
				inValid <= 1'b0;
				@(negedge clk);
				checkFlag(1'b1, outValid, "outValid");
				checkRes(toDim(r.expected), r.expected == 0);
			end
		end

		$display("errors: result %0d, op %0d, flag %0d over %0d rows",
			resErrors, opErrors, flagErrors, stim.size());
		if (resErrors + opErrors + flagErrors == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

endmodule

/* dv/ClkGen.sv */
`timescale 1ns/10ps

module ClkGen #(
	parameter int period      = 20, // ns
	parameter int resetCycles = 3
) (
	output logic clk,
	output logic rstN
);

	initial begin
		clk = 1'b0;
		forever #(period/2) clk = ~clk;
	end

	// sync reset released on a rising edge
	initial begin
		rstN = 1'b0;
		repeat (resetCycles) @(posedge clk);
		rstN <= 1'b1;
	end

endmodule

/* logic/ModAluTop.sv */
`timescale 1ns/10ps

module ModAluTop #(
	parameter int width = modPkg::defaultWidth,
	parameter int speed = modPkg::defaultSpeed
) (
	input  logic                        clk,
	input  logic                        rstN,
	input  logic                        cfgWe,
	input  logic [modPkg::cfgWidth-1:0] cfgData,
	input  logic                        inValid,
	input  logic [width-1:0]            aVal,
	input  logic                        aZero,
	input  logic [width-1:0]            bVal,
	input  logic                        bZero,
	output logic                        outValid,
	output logic [width-1:0]            resVal,
	output logic                        resZero
);

	ModCfgIf #(.width(width)) cfgBus ();

	ModCfgReg #(
		.width(width)
	) cfgReg (
		.clk    (clk),
		.rstN   (rstN),
		.cfgWe  (cfgWe),
		.cfgData(cfgData),
		.aVal   (aVal),    // load value comes from a
		.aZero  (aZero),
		.cfgBus (cfgBus.cfg)
	);

	ModResidueUnit #(
		.width(width),
		.speed(speed)
	) residue (
		.clk     (clk),
		.rstN    (rstN),
		.inValid (inValid),
		.aVal    (aVal),
		.aZero   (aZero),
		.bVal    (bVal),
		.bZero   (bZero),
		.cfgBus  (cfgBus.unit),
		.outValid(outValid),
		.resVal  (resVal),
		.resZero (resZero)
	);

endmodule

/* logic/ModResidueUnit.sv */
`timescale 1ns/10ps

module ModResidueUnit #(
	parameter int width = modPkg::defaultWidth,
	parameter int speed = modPkg::defaultSpeed
) (
	input  logic             clk,
	input  logic             rstN,
	input  logic             inValid,
	input  logic [width-1:0] aVal,    // diminished-one
	input  logic             aZero,
	input  logic [width-1:0] bVal,
	input  logic             bZero,
	ModCfgIf.unit            cfgBus,
	output logic             outValid,
	output logic [width-1:0] resVal,
	output logic             resZero
);
	import modPkg::*;

	logic             accMode;
	logic [width-1:0] acc;               // running residue
	logic             accZero;
	logic [width-1:0] secVal, opB, sum;  // second operand path
	logic             secZero, cancel;
	logic [width-1:0] nextVal;
	logic             nextZero;

	assign accMode = (cfgBus.op == opAcc);
	assign secVal  = accMode ? acc : bVal;   // b ignored when accumulating
	assign secZero = accMode ? accZero : bZero;
	assign opB     = (cfgBus.op == opSub) ? ~secVal : secVal; // -x is ~(x-1)
	assign cancel  = &(aVal ^ opB); // x + y == modulus

	AddMod2Np1 #(
		.width(width),
		.speed(speed)
	) adder (
		.A(aVal),
		.B(opB),
		.S(sum)
	);

	always_comb begin
		nextZero = 1'b0;
		nextVal  = sum;
		if (aZero) begin
			nextZero = secZero;                  // 0 + y
			nextVal  = secZero ? '0 : opB;
		end else if (secZero) begin
			nextVal = aVal;                      // x + 0
		end else if (cancel) begin
			nextZero = 1'b1;
			nextVal  = '0;
		end
	end

	always_ff @(posedge clk) begin
		if (!rstN) begin
			acc     <= '0;
			accZero <= 1'b1;
		end else if (cfgBus.accClr) begin
			acc     <= '0;
			accZero <= 1'b1;
		end else if (cfgBus.accLoad) begin
			acc     <= cfgBus.loadZero ? '0 : cfgBus.loadVal;
			accZero <= cfgBus.loadZero;
		end else if (inValid && accMode) begin
			acc     <= nextVal; // same edge as the output
			accZero <= nextZero;
		end
	end

	always_ff @(posedge clk) begin
		if (!rstN) outValid <= 1'b0;
		else       outValid <= inValid;
	end

	always_ff @(posedge clk) begin
		if (inValid) begin
			resVal  <= nextVal;
			resZero <= nextZero;
		end
	end

	zeroClean: assert property (@(posedge clk) disable iff (!rstN)
		outValid && resZero |-> resVal == '0)
		else $error("zero result with nonzero value");

	latencyOne: assert property (@(posedge clk) disable iff (!rstN)
		inValid |=> outValid)
		else $error("result missing one cycle after strobe");

	noSpurious: assert property (@(posedge clk) disable iff (!rstN)
		!inValid |=> !outValid)
		else $error("result without a strobe");

endmodule

/* logic/ModCfgReg.sv */
`timescale 1ns/10ps

module ModCfgReg #(
	parameter int width = modPkg::defaultWidth
) (
	input  logic                        clk,
	input  logic                        rstN,
	input  logic                        cfgWe,   // write strobe
	input  logic [modPkg::cfgWidth-1:0] cfgData,
	input  logic [width-1:0]            aVal,    // load source
	input  logic                        aZero,
	ModCfgIf.cfg                        cfgBus
);
	import modPkg::*;

	logic [1:0] opField;
	logic       clrReq, loadReq;

	assign opField = cfgData[cfgOpLsb +: 2];
	assign clrReq  = cfgData[cfgClrBit];
	assign loadReq = cfgData[cfgLoadBit];

	always_ff @(posedge clk) begin
		if (!rstN) begin
			cfgBus.op      <= opAdd;
			cfgBus.accClr  <= 1'b0;
			cfgBus.accLoad <= 1'b0;
		end else begin
			cfgBus.accClr  <= cfgWe & clrReq;
			cfgBus.accLoad <= cfgWe & loadReq & ~clrReq; // clear wins
			if (cfgWe && opField != opRsvd) begin
				cfgBus.op <= modOpE'(opField); // reserved code keeps old op
			end
		end
	end

	// load operand sampled with the write
	always_ff @(posedge clk) begin
		if (cfgWe) begin
			cfgBus.loadVal  <= aVal;
			cfgBus.loadZero <= aZero;
		end
	end

	opLegal: assert property (@(posedge clk) disable iff (!rstN)
		cfgBus.op != opRsvd)
		else $error("op register holds reserved code");

	pulseExcl: assert property (@(posedge clk) disable iff (!rstN)
		!(cfgBus.accClr && cfgBus.accLoad))
		else $error("accumulator clear and load together");

endmodule

/* logic/ModCfgIf.sv */
`timescale 1ns/10ps

interface ModCfgIf #(
	parameter int width = modPkg::defaultWidth
);
	import modPkg::*;

	modOpE            op;       // current operation, level
	logic             accClr;   // one-cycle pulse
	logic             accLoad;  // one-cycle pulse
	logic [width-1:0] loadVal;  // a captured at the write
	logic             loadZero; // its zero flag

	modport cfg (
		output op, accClr, accLoad, loadVal, loadZero
	);

	modport unit (
		input op, accClr, accLoad, loadVal, loadZero
	);

endinterface

/* logic/AddMod2Np1.sv */
`timescale 1ns/10ps

// diminished-one sum of two nonzero residues mod 2^width+1
module AddMod2Np1 #(
	parameter int width = modPkg::defaultWidth,
	parameter int speed = modPkg::defaultSpeed
) (
	input  logic [width-1:0] A, // diminished operands
	input  logic [width-1:0] B,
	output logic [width-1:0] S  // diminished sum
);

	logic [width-1:0] gIn, pIn;   // prefix inputs
	logic [width-1:0] gOut;       // carries
	logic [width-1:0] halfSum;    // a xor b
	logic             cIn, cOut;  // end-around pair

	assign gIn     = A & B;
	assign pIn     = A | B;
	assign halfSum = ~gIn & pIn;

	PrefixAndOrCendaround #(
		.width(width),
		.speed(speed)
	) prefix (
		.GI(gIn),
		.PI(pIn),
		.CI(cIn),
		.GO(gOut),
		.PO(),
		.CO(cOut)
	);

	// inverted carry out re-enters at bit 0
	assign cIn = ~cOut;

	assign S = halfSum ^ {gOut[width-2:0], cIn};

endmodule

/* logic/PrefixAndOrCendaround.sv */
`timescale 1ns/10ps

module PrefixAndOrCendaround #(
	parameter int width = modPkg::defaultWidth,
	parameter int speed = modPkg::defaultSpeed
) (
	input  logic [width-1:0] GI, // generate in
	input  logic [width-1:0] PI, // propagate in
	input  logic             CI, // end-around carry in
	output logic [width-1:0] GO, // carries incl. carry in
	output logic [width-1:0] PO,
	output logic             CO  // carry out without CI
);

	logic [width-1:0] gT, pT; // plain prefix result

	PrefixAndOr #(
		.width(width),
		.speed(speed)
	) prefix (
		.GI(GI),
		.PI(PI),
		.GO(gT),
		.PO(pT)
	);

	assign CO = gT[width-1]; // taken before CI so no loop

	// one extra and-or level folds in the carry in
	assign GO = gT | (pT & {width{CI}});
	assign PO = pT;

endmodule

/* logic/PrefixAndOr.sv */
`timescale 1ns/10ps

module PrefixAndOr #(
	parameter int width = modPkg::defaultWidth, // word width
	parameter int speed = modPkg::defaultSpeed  // 0 serial, 1 brent-kung, 2 sklansky
) (
	input  logic [width-1:0] GI, // generate in
	input  logic [width-1:0] PI, // propagate in
	output logic [width-1:0] GO, // prefix generate out
	output logic [width-1:0] PO  // prefix propagate out
);

	localparam int m = $clog2(width); // log depth of the trees

	if (speed == 2) begin : gSklansky
		// level l lives at bits [l*width +: width]
		logic [(m+1)*width-1:0] gT, pT;

		assign gT[width-1:0] = GI;
		assign pT[width-1:0] = PI;

		for (genvar l = 1; l <= m; l++) begin : gLvl
			for (genvar j = 0; j < width; j++) begin : gBit
				// upper half of each 2^l block takes the top of the lower half
				if (((j >> (l-1)) & 1) == 1) begin : gBlack
					localparam int src = ((j >> l) << l) + 2**(l-1) - 1;
					assign gT[l*width+j] = gT[(l-1)*width+j]
						| (pT[(l-1)*width+j] & gT[(l-1)*width+src]);
					assign pT[l*width+j] = pT[(l-1)*width+j] & pT[(l-1)*width+src];
				end else begin : gWhite
					assign gT[l*width+j] = gT[(l-1)*width+j]; // pass
					assign pT[l*width+j] = pT[(l-1)*width+j];
				end
			end
		end

		assign GO = gT[m*width +: width];
		assign PO = pT[m*width +: width];
	end else if (speed == 1) begin : gBrentKung
		localparam int depth = 2*m - 1; // up-sweep m levels, down-sweep m-1

		logic [(depth+1)*width-1:0] gT, pT;

		assign gT[width-1:0] = GI;
		assign pT[width-1:0] = PI;

		for (genvar l = 1; l <= depth; l++) begin : gLvl
			for (genvar j = 0; j < width; j++) begin : gBit
				localparam bit up = (l <= m);
				localparam int d  = up ? l : 2*m - l; // block exponent at this level
				// up-sweep merges block tops, down-sweep fills mid points
				localparam bit black = up ? (((j+1) % 2**d) == 0)
					: ((((j+1) % 2**d) == 2**(d-1)) && (j >= 2**d));

				if (black) begin : gBlack
					localparam int src = j - 2**(d-1);
					// proper generate merge
					assign gT[l*width+j] = gT[(l-1)*width+j]
						| (pT[(l-1)*width+j] & gT[(l-1)*width+src]);
					assign pT[l*width+j] = pT[(l-1)*width+j] & pT[(l-1)*width+src];
				end else begin : gWhite
					assign gT[l*width+j] = gT[(l-1)*width+j];
					assign pT[l*width+j] = pT[(l-1)*width+j];
				end
			end
		end

		assign GO = gT[depth*width +: width];
		assign PO = pT[depth*width +: width];
	end else begin : gSerial
		// ripple chain for the smallest area
		logic [width-1:0] gT, pT;

		assign gT[0] = GI[0];
		assign pT[0] = PI[0];

		for (genvar i = 1; i < width; i++) begin : gBit
			assign gT[i] = GI[i] | (PI[i] & gT[i-1]);
			assign pT[i] = PI[i] & pT[i-1];
		end

		assign GO = gT;
		assign PO = pT;
	end

endmodule

/* logic/modPkg.sv */
package modPkg;

	// operation select with value 3 reserved
	typedef enum logic [1:0] {
		opAdd = 2'd0, // a + b
		opSub = 2'd1, // a - b
		opAcc = 2'd2  // acc + a
	} modOpE;

	localparam logic [1:0] opRsvd = 2'd3; // rejected on write

	// config word layout
	localparam int cfgWidth   = 4;
	localparam int cfgOpLsb   = 0; // op in bits 1..0
	localparam int cfgClrBit  = 2; // accumulator clear request
	localparam int cfgLoadBit = 3; // accumulator load from a

	// top level defaults
	localparam int defaultWidth = 8;
	localparam int defaultSpeed = 1; // brent-kung

endpackage
